// ==== rename_pkg.sv ====
package rename_pkg;

  // architectural register file size, x0 included
  localparam int NUM_ARCH_REGS = 32;

  // physical register file size
  // the first NUM_ARCH_REGS entries hold the reset mapping
  localparam int NUM_PHYS_REGS = 64;

  // index widths
  localparam int ARCH_W = $clog2(NUM_ARCH_REGS);
  localparam int PHYS_W = $clog2(NUM_PHYS_REGS);

  // slots renamed per cycle
  // also the number of free list offers and commit free ports
  localparam int RENAME_WIDTH = 2;

endpackage

// ==== first_bit_finder.sv ====
`timescale 1ns/1ps

module first_bit_finder import rename_pkg::*; (
  input  logic [NUM_PHYS_REGS-1:0] bits,
  // 1 looks for the lowest set bit, 0 for the lowest clear bit
  input  logic                     find_true,
  output logic [PHYS_W-1:0]        first_index,
  // low when every bit has the other value
  output logic                     found
);

  logic [NUM_PHYS_REGS-1:0] target_bits;

  // fold the polarity in so the scan only looks for ones
  always_comb begin
    target_bits = find_true ? bits : ~bits;
  end

  // scan from the top down
  // a lower hit overwrites a higher one, so the lowest index wins
  always_comb begin
    first_index = '0;
    found       = 1'b0;
    for (int i = NUM_PHYS_REGS - 1; i >= 0; i--) begin
      if (target_bits[i]) begin
        first_index = PHYS_W'(i);
        found       = 1'b1;
      end
    end
  end

endmodule

// ==== free_list.sv ====
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst,
  // from the rat
  // take[0] uses offer 0
  // take[1] uses offer 0 when slot 0 takes nothing, else offer 1
  input  logic [RENAME_WIDTH-1:0]              take,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  free_preg_offer,
  output logic [RENAME_WIDTH-1:0]              free_avail,
  // commit frees
  input  logic [RENAME_WIDTH-1:0]              free_valid,
  input  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  free_preg
);

  // one bit per physical register, set while the register is mapped or in flight
  logic [NUM_PHYS_REGS-1:0] in_use;
  logic [NUM_PHYS_REGS-1:0] in_use_nxt;
  // in-use map with offer 0 treated as taken, for the second search
  logic [NUM_PHYS_REGS-1:0] in_use_masked;
  // index consumed by slot 1's take
  logic [PHYS_W-1:0]        take1_preg;

  // lowest clear bit of the map
  first_bit_finder first_free_inst (
    .bits        (in_use),
    .find_true   (1'b0),
    .first_index (free_preg_offer[0]),
    .found       (free_avail[0])
  );

  // hide offer 0 so the second finder returns the next lowest
  always_comb begin
    in_use_masked = in_use;
    if (free_avail[0]) begin
      in_use_masked[free_preg_offer[0]] = 1'b1;
    end
  end

  first_bit_finder second_free_inst (
    .bits        (in_use_masked),
    .find_true   (1'b0),
    .first_index (free_preg_offer[1]),
    .found       (free_avail[1])
  );

  // slot 1 falls back to offer 0 if slot 0 left it untouched
  assign take1_preg = take[0] ? free_preg_offer[1] : free_preg_offer[0];

  // frees clear first, then takes set
  // same index freed and taken in one cycle is excluded upstream
  always_comb begin
    in_use_nxt = in_use;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (free_valid[i]) begin
        in_use_nxt[free_preg[i]] = 1'b0;
      end
    end
    if (take[0]) begin
      in_use_nxt[free_preg_offer[0]] = 1'b1;
    end
    if (take[1]) begin
      in_use_nxt[take1_preg] = 1'b1;
    end
  end

  // reset state: the identity mapping holds registers 0 .. NUM_ARCH_REGS-1
  always_ff @(posedge clk) begin
    if (!rst) begin
      in_use <= {{(NUM_PHYS_REGS - NUM_ARCH_REGS){1'b0}}, {NUM_ARCH_REGS{1'b1}}};
    end else begin
      in_use <= in_use_nxt;
    end
  end

  // the rat may only consume offers that exist
  // this ties the rat's ready computation to the offers made here
  take0_has_offer: assert property (
    @(posedge clk) disable iff (!rst)
    take[0] |-> free_avail[0]
  ) else $error("take[0] without an available offer");

  take1_has_offer: assert property (
    @(posedge clk) disable iff (!rst)
    take[1] |-> (take[0] ? free_avail[1] : free_avail[0])
  ) else $error("take[1] without an available offer");

  for (genvar g = 0; g < RENAME_WIDTH; g++) begin : gen_free_checks
    // commit can only release what rename handed out
    free_is_in_use: assert property (
      @(posedge clk) disable iff (!rst)
      free_valid[g] |-> in_use[free_preg[g]]
    ) else $error("free of physical register %0d that is not in use", free_preg[g]);

    // p0 backs x0 forever
    free_not_zero: assert property (
      @(posedge clk) disable iff (!rst)
      free_valid[g] |-> (free_preg[g] != '0)
    ) else $error("free of physical register 0");
  end

endmodule

// ==== rat.sv ====
`timescale 1ns/1ps

module rat import rename_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst,
  // decoded slots from upstream
  input  logic [RENAME_WIDTH-1:0]              in_valid,
  input  logic [RENAME_WIDTH-1:0][ARCH_W-1:0]  src1_arch,
  input  logic [RENAME_WIDTH-1:0][ARCH_W-1:0]  src2_arch,
  input  logic [RENAME_WIDTH-1:0][ARCH_W-1:0]  dst_arch,
  input  logic [RENAME_WIDTH-1:0]              dst_wr,
  // level stall from the rob
  input  logic                                 rob_stall,
  output logic                                 ready,
  // free list offers
  input  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  free_preg_offer,
  input  logic [RENAME_WIDTH-1:0]              free_avail,
  output logic [RENAME_WIDTH-1:0]              take,
  // renamed slots, one cycle after accept
  output logic [RENAME_WIDTH-1:0]              out_valid,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  src1_phys,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  src2_phys,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  dst_phys,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  old_dst_phys
);

  // architectural to physical map
  logic [NUM_ARCH_REGS-1:0][PHYS_W-1:0] map_table;

  // slot really allocates: live, writes, and not x0
  logic [RENAME_WIDTH-1:0]              wr;
  logic                                 accept;
  // register each slot would get
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  new_phys;
  // combinational rename results, before the output registers
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  src1_rd;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  src2_rd;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  old_rd;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  dst_rd;

  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      wr[i] = in_valid[i] && dst_wr[i] && (dst_arch[i] != '0);
    end
  end

  // enough offers for every allocating slot, and the rob can take results
  // offer 1 only exists when offer 0 does
  always_comb begin
    if (rob_stall) begin
      ready = 1'b0;
    end else if (wr[0] && wr[1]) begin
      ready = free_avail[1];
    end else if (wr[0] || wr[1]) begin
      ready = free_avail[0];
    end else begin
      ready = 1'b1;
    end
  end

  assign accept = ready && (|in_valid);

  // slot 1 gets offer 0 when slot 0 does not allocate
  assign new_phys[0] = free_preg_offer[0];
  assign new_phys[1] = wr[0] ? free_preg_offer[1] : free_preg_offer[0];

  assign take[0] = accept && wr[0];
  assign take[1] = accept && wr[1];

  // table reads plus the slot 0 to slot 1 bypass
  // x0 never hits the bypass because wr[0] excludes it
  always_comb begin
    src1_rd[0] = map_table[src1_arch[0]];
    src2_rd[0] = map_table[src2_arch[0]];
    old_rd[0]  = map_table[dst_arch[0]];

    src1_rd[1] = map_table[src1_arch[1]];
    src2_rd[1] = map_table[src2_arch[1]];
    old_rd[1]  = map_table[dst_arch[1]];
    if (wr[0] && (src1_arch[1] == dst_arch[0])) begin
      src1_rd[1] = new_phys[0];
    end
    if (wr[0] && (src2_arch[1] == dst_arch[0])) begin
      src2_rd[1] = new_phys[0];
    end
    // WAW inside the group: slot 1 replaces slot 0's fresh mapping
    if (wr[0] && (dst_arch[1] == dst_arch[0])) begin
      old_rd[1] = new_phys[0];
    end

    // non-writing slots report the mapping they see
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      dst_rd[i] = wr[i] ? new_phys[i] : old_rd[i];
    end
  end

  // map table, identity after reset
  // slot 1 is written last so it wins on a shared destination
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_table[i] <= PHYS_W'(i);
      end
    end else if (accept) begin
      if (wr[0]) begin
        map_table[dst_arch[0]] <= new_phys[0];
      end
      if (wr[1]) begin
        map_table[dst_arch[1]] <= new_phys[1];
      end
    end
  end

  // out_valid follows accept, drops when idle, holds under stall
  always_ff @(posedge clk) begin
    if (!rst) begin
      out_valid <= '0;
    end else if (accept) begin
      out_valid <= in_valid;
    end else if (!rob_stall) begin
      out_valid <= '0;
    end
  end

  // payload only loads on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      src1_phys    <= src1_rd;
      src2_phys    <= src2_rd;
      dst_phys     <= dst_rd;
      old_dst_phys <= old_rd;
    end
  end

  // two allocations in one group need two different registers
  // depends on the free list offering distinct indices
  take_distinct: assert property (
    @(posedge clk) disable iff (!rst)
    (take[0] && take[1]) |-> (new_phys[0] != new_phys[1])
  ) else $error("both slots allocated physical register %0d", new_phys[0]);

endmodule

// ==== rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst,
  // decoded slots
  input  logic [RENAME_WIDTH-1:0]              in_valid,
  input  logic [RENAME_WIDTH-1:0][ARCH_W-1:0]  src1_arch,
  input  logic [RENAME_WIDTH-1:0][ARCH_W-1:0]  src2_arch,
  input  logic [RENAME_WIDTH-1:0][ARCH_W-1:0]  dst_arch,
  input  logic [RENAME_WIDTH-1:0]              dst_wr,
  // commit frees
  input  logic [RENAME_WIDTH-1:0]              free_valid,
  input  logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  free_preg,
  input  logic                                 rob_stall,
  output logic                                 ready,
  // renamed slots
  output logic [RENAME_WIDTH-1:0]              out_valid,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  src1_phys,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  src2_phys,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  dst_phys,
  output logic [RENAME_WIDTH-1:0][PHYS_W-1:0]  old_dst_phys
);

  // free list to rat
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0] free_preg_offer;
  logic [RENAME_WIDTH-1:0]             free_avail;
  // rat to free list
  logic [RENAME_WIDTH-1:0]             take;

  rat rat_inst (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (in_valid),
    .src1_arch       (src1_arch),
    .src2_arch       (src2_arch),
    .dst_arch        (dst_arch),
    .dst_wr          (dst_wr),
    .rob_stall       (rob_stall),
    .ready           (ready),
    .free_preg_offer (free_preg_offer),
    .free_avail      (free_avail),
    .take            (take),
    .out_valid       (out_valid),
    .src1_phys       (src1_phys),
    .src2_phys       (src2_phys),
    .dst_phys        (dst_phys),
    .old_dst_phys    (old_dst_phys)
  );

  // offers are combinational, so takes and frees land on the same edge
  free_list free_list_inst (
    .clk             (clk),
    .rst             (rst),
    .take            (take),
    .free_preg_offer (free_preg_offer),
    .free_avail      (free_avail),
    .free_valid      (free_valid),
    .free_preg       (free_preg)
  );

endmodule

// ==== rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

  localparam int PERIOD       = 8;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_VECS     = 128;
  localparam int NUM_FIELDS   = 24;
  // idle cycles after a test group, at least one so its last outputs get checked
  localparam int MAX_GAP      = 3;
  // vector columns
  localparam int F_TID   = 0;
  localparam int F_IV    = 1;
  // four per slot: src1, src2, dst, dst_wr
  localparam int F_SLOT  = 2;
  localparam int F_FV    = 10;
  localparam int F_FP0   = 11;
  localparam int F_FP1   = 12;
  localparam int F_STALL = 13;
  localparam int F_READY = 14;
  localparam int F_OV    = 15;
  // four per slot: src1, src2, dst, old dst
  localparam int F_OUT   = 16;
  // pending index meaning out_valid should be zero
  localparam int IDLE    = -1;

  logic                                clk;
  logic                                rst;
  logic [RENAME_WIDTH-1:0]             in_valid;
  logic [RENAME_WIDTH-1:0][ARCH_W-1:0] src1_arch;
  logic [RENAME_WIDTH-1:0][ARCH_W-1:0] src2_arch;
  logic [RENAME_WIDTH-1:0][ARCH_W-1:0] dst_arch;
  logic [RENAME_WIDTH-1:0]             dst_wr;
  logic [RENAME_WIDTH-1:0]             free_valid;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0] free_preg;
  logic                                rob_stall;
  logic                                ready;
  logic [RENAME_WIDTH-1:0]             out_valid;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0] src1_phys;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0] src2_phys;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0] dst_phys;
  logic [RENAME_WIDTH-1:0][PHYS_W-1:0] old_dst_phys;

  int vecs [0:MAX_VECS-1][0:NUM_FIELDS-1];
  int vec_line [0:MAX_VECS-1];
  int gap_after [0:MAX_VECS-1];
  int num_vecs;
  int total_gaps;
  int limit_cycles;
  int pend_idx;
  int errors;
  int total_checks;
  int test_errors;
  int test_checks;
  int tests_run;
  int tests_failed;

  rename_stage rename_stage_inst (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .src1_arch    (src1_arch),
    .src2_arch    (src2_arch),
    .dst_arch     (dst_arch),
    .dst_wr       (dst_wr),
    .free_valid   (free_valid),
    .free_preg    (free_preg),
    .rob_stall    (rob_stall),
    .ready        (ready),
    .out_valid    (out_valid),
    .src1_phys    (src1_phys),
    .src2_phys    (src2_phys),
    .dst_phys     (dst_phys),
    .old_dst_phys (old_dst_phys)
  );

  always #(PERIOD / 2) clk = ~clk;

  // limit is known once the vectors and gaps are in
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * PERIOD * 2);
    $display("timeout: run did not finish within %0d cycles", limit_cycles * 2);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic string test_name(input int tid);
    case (tid)
      1: return "reset mapping";
      2: return "allocation order";
      3: return "intra-group bypass";
      4: return "x0 destinations";
      5: return "free list exhaustion";
      6: return "rob stall";
      default: return "unnamed";
    endcase
  endfunction

  // lines that do not parse as 24 numbers are comments or blank
  task automatic load_vectors();
    int    fd;
    int    n;
    int    line_no;
    int    f [0:NUM_FIELDS-1];
    string line;
    num_vecs = 0;
    line_no  = 0;
    fd = $fopen("rename_vectors.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        line_no++;
        n = $sscanf(line, "%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                    f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23]);
        if (n == NUM_FIELDS && num_vecs < MAX_VECS) begin
          for (int k = 0; k < NUM_FIELDS; k++) begin
            vecs[num_vecs][k] = f[k];
          end
          vec_line[num_vecs] = line_no;
          num_vecs++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_vector(input int idx);
    logic [RENAME_WIDTH-1:0][ARCH_W-1:0] s1;
    logic [RENAME_WIDTH-1:0][ARCH_W-1:0] s2;
    logic [RENAME_WIDTH-1:0][ARCH_W-1:0] d;
    logic [RENAME_WIDTH-1:0]             w;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      s1[s] = ARCH_W'(vecs[idx][F_SLOT + 4 * s]);
      s2[s] = ARCH_W'(vecs[idx][F_SLOT + 4 * s + 1]);
      d[s]  = ARCH_W'(vecs[idx][F_SLOT + 4 * s + 2]);
      w[s]  = vecs[idx][F_SLOT + 4 * s + 3] != 0;
    end
    in_valid     <= RENAME_WIDTH'(vecs[idx][F_IV]);
    src1_arch    <= s1;
    src2_arch    <= s2;
    dst_arch     <= d;
    dst_wr       <= w;
    free_valid   <= RENAME_WIDTH'(vecs[idx][F_FV]);
    free_preg[0] <= PHYS_W'(vecs[idx][F_FP0]);
    free_preg[1] <= PHYS_W'(vecs[idx][F_FP1]);
    rob_stall    <= vecs[idx][F_STALL] != 0;
  endtask

  task automatic drive_idle();
    in_valid   <= '0;
    dst_wr     <= '0;
    free_valid <= '0;
    rob_stall  <= 1'b0;
  endtask

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_ready(input int idx);
    test_checks++;
    assert (ready == (vecs[idx][F_READY] != 0)) else begin
      $display("FAIL %0t: line %0d ready is %0b, expected %0d",
               $time, vec_line[idx], ready, vecs[idx][F_READY]);
      note_error();
    end
  endtask

  task automatic compare_phys(input string what, input int slot, input int idx,
                              input logic [PHYS_W-1:0] got, input int exp);
    test_checks++;
    assert (got == PHYS_W'(exp)) else begin
      $display("FAIL %0t: line %0d slot %0d %s is %0d, expected %0d",
               $time, vec_line[idx], slot, what, got, exp);
      note_error();
    end
  endtask

  // outputs of the vector accepted one cycle earlier
  task automatic check_outputs(input int idx);
    logic [RENAME_WIDTH-1:0] exp_ov;
    int                      base;
    exp_ov = (idx == IDLE) ? '0 : RENAME_WIDTH'(vecs[idx][F_OV]);
    test_checks++;
    assert (out_valid == exp_ov) else begin
      $display("FAIL %0t: out_valid is %b, expected %b after line %0d",
               $time, out_valid, exp_ov, (idx == IDLE) ? 0 : vec_line[idx]);
      note_error();
    end
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      // payload is only meaningful on a live slot
      if (exp_ov[s]) begin
        base = F_OUT + 4 * s;
        compare_phys("src1_phys", s, idx, src1_phys[s], vecs[idx][base]);
        compare_phys("src2_phys", s, idx, src2_phys[s], vecs[idx][base + 1]);
        compare_phys("dst_phys", s, idx, dst_phys[s], vecs[idx][base + 2]);
        compare_phys("old_dst_phys", s, idx, old_dst_phys[s], vecs[idx][base + 3]);
      end
    end
  endtask

  task automatic finish_test(input int tid);
    tests_run++;
    total_checks += test_checks;
    if (test_errors == 0) begin
      $display("test %0d (%s): ok, %0d checks", tid, test_name(tid), test_checks);
    end else begin
      tests_failed++;
      $display("test %0d (%s): %0d of %0d checks wrong",
               tid, test_name(tid), test_errors, test_checks);
    end
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic run_vectors();
    // the first cycle also checks out_valid low after reset
    pend_idx = IDLE;
    for (int i = 0; i < num_vecs; i++) begin
      @(posedge clk);
      drive_vector(i);
      @(negedge clk);
      check_outputs(pend_idx);
      check_ready(i);
      pend_idx = i;
      for (int g = 0; g < gap_after[i]; g++) begin
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_outputs(pend_idx);
        pend_idx = IDLE;
      end
      if (gap_after[i] > 0) begin
        finish_test(vecs[i][F_TID]);
      end
    end
  endtask

  initial begin
    void'($urandom(12356));
    clk        = 1'b0;
    rst        = 1'b0;
    in_valid   = '0;
    src1_arch  = '0;
    src2_arch  = '0;
    dst_arch   = '0;
    dst_wr     = '0;
    free_valid = '0;
    free_preg  = '0;
    rob_stall  = 1'b0;
    load_vectors();
    if (num_vecs == 0) begin
      $display("could not read any vectors from rename_vectors.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      // idle gap after the last line of each test group
      total_gaps = 0;
      for (int i = 0; i < num_vecs; i++) begin
        if (i == num_vecs - 1 || vecs[i + 1][F_TID] != vecs[i][F_TID]) begin
          gap_after[i] = 1 + int'($urandom % MAX_GAP);
        end else begin
          gap_after[i] = 0;
        end
        total_gaps += gap_after[i];
      end
      limit_cycles = num_vecs + total_gaps + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b1;
      run_vectors();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, total_checks, errors);
      if (errors == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== rename_vectors.txt ====
# tid iv  s1_0 s2_0 dst_0 wr_0  s1_1 s2_1 dst_1 wr_1  fv fp0 fp1 stall  ready ov
#   s1p_0 s2p_0 dp_0 odp_0  s1p_1 s2p_1 dp_1 odp_1   (outputs one cycle later, decimal)
# test 1: identity mapping after reset, nothing allocated
1 3  1  2  0 0  30 31  0 0  0  0  0 0  1 3   1  2  0  0  30 31  0  0
1 1  7 15  9 0   0  0  0 0  0  0  0 0  1 1   7 15  9  9   0  0  0  0
# test 2: lowest free indices in slot order, slot 1 alone takes offer 0
2 3  1  2  5 1   3  4  6 1  0  0  0 0  1 3   1  2 32  5   3  4 33  6
2 3  5  6  7 1   7  5  8 1  0  0  0 0  1 3  32 33 34  7  34 32 35  8
2 2  0  0  3 1   8  6 10 1  0  0  0 0  1 2   0  0  0  0  35 33 36 10
# test 3: slot 1 reads slot 0's destination, then both write r13
3 3  1  2 11 1  11 11 12 1  0  0  0 0  1 3   1  2 37 11  37 37 38 12
3 3 13  0 13 1  13 12 13 1  0  0  0 0  1 3  13  0 39 13  39 38 40 39
3 1 13 11  0 0   0  0  0 0  0  0  0 0  1 1  40 37  0  0   0  0  0  0
# test 4: x0 destinations allocate nothing
4 3  0  0  0 1   0  3  0 1  0  0  0 0  1 3   0  0  0  0   0  3  0  0
4 3  0  5  0 1   4  0 14 1  0  0  0 0  1 3   0 32  0  0   4  0 41 14
# test 5: use up 42..63, then free and refill lowest first
5 3 15  0 15 1  16  0 16 1  0  0  0 0  1 3  15  0 42 15  16  0 43 16
5 3 17  0 17 1  18  0 18 1  0  0  0 0  1 3  17  0 44 17  18  0 45 18
5 3 19  0 19 1  20  0 20 1  0  0  0 0  1 3  19  0 46 19  20  0 47 20
5 3 21  0 21 1  22  0 22 1  0  0  0 0  1 3  21  0 48 21  22  0 49 22
5 3 23  0 23 1  24  0 24 1  0  0  0 0  1 3  23  0 50 23  24  0 51 24
5 3 25  0 25 1  26  0 26 1  0  0  0 0  1 3  25  0 52 25  26  0 53 26
5 3 27  0 27 1  28  0 28 1  0  0  0 0  1 3  27  0 54 27  28  0 55 28
5 3 29  0 29 1  30  0 30 1  0  0  0 0  1 3  29  0 56 29  30  0 57 30
5 3 31  0 31 1   1  0  1 1  0  0  0 0  1 3  31  0 58 31   1  0 59  1
5 3  2  0  2 1   3  0  3 1  0  0  0 0  1 3   2  0 60  2   3  0 61  3
5 3  4  0  4 1   5  0  5 1  0  0  0 0  1 3   4  0 62  4  32  0 63 32
# list empty: ready low, slots held, frees of 39 and 32 land on the second cycle
5 3  6  0  6 1   6  0  7 1  0  0  0 0  0 0   0  0  0  0   0  0  0  0
5 3  6  0  6 1   6  0  7 1  3 39 32 0  0 0   0  0  0  0   0  0  0  0
5 3  6  0  6 1   6  0  7 1  0  0  0 0  1 3  33  0 32 33  32  0 39 34
5 1  7  6  8 1   0  0  0 0  1 33  0 0  0 0   0  0  0  0   0  0  0  0
5 1  7  6  8 1   0  0  0 0  0  0  0 0  1 1  39 32 33 35   0  0  0  0
# test 6: outputs hold under rob_stall, new result one cycle after release
6 0  0  0  0 0   0  0  0 0  3 34 35 0  1 0   0  0  0  0   0  0  0  0
6 3  8  0  9 1   9  0  0 0  0  0  0 0  1 3  33  0 34  9  34  0  0  0
6 1  9  0 10 1   0  0  0 0  0  0  0 1  0 3  33  0 34  9  34  0  0  0
6 1  9  0 10 1   0  0  0 0  0  0  0 1  0 3  33  0 34  9  34  0  0  0
6 1  9  0 10 1   0  0  0 0  0  0  0 0  1 1  34  0 35 36   0  0  0  0
6 1 10  9  0 0   0  0  0 0  0  0  0 0  1 1  35 34  0  0   0  0  0  0

// ==== rename.f ====
rename_pkg.sv
first_bit_finder.sv
free_list.sv
rat.sv
rename_stage.sv
rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename

sources:
  - rename_pkg.sv
  - first_bit_finder.sv
  - free_list.sv
  - rat.sv
  - rename_stage.sv
  - target: test
    files:
      - rename_tb.sv
